// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pdp_sub
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(BUILD_DIR)/V%: $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$*

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+.
pdp_bus_pkg.sv
bus_arbiter.sv
line_clock.sv
fill_dma.sv
iopage.sv
bus.sv
word_ram.sv
pdp_sub_top.sv
tb_pdp_sub.sv

// File: bus.sv
`timescale 1ns/1ps

module bus #(
   parameter int RAM_BYTES   = 16384,
   parameter int TICK_CYCLES = 64
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] bus_addr,
   input  logic [15:0] bus_data_in,
   input  logic        bus_rd,
   input  logic        bus_wr,
   input  logic        bus_byte_op,
   input  logic        bus_arbitrate,
   input  logic [15:0] switches,
   input  logic [7:0]  interrupt_ack_ipl,
   output logic [15:0] bus_data_out,
   output logic        bus_ack,
   output logic        bus_error,
   output logic        bus_int,
   output logic [7:0]  bus_int_ipl,
   output logic [7:0]  bus_int_vector,
   output logic [15:0] display,
   output logic [21:0] ram_addr,
   output logic [15:0] ram_data_out,
   output logic        ram_rd,
   output logic        ram_wr,
   output logic        ram_byte_op,
   input  logic [15:0] ram_data_in
);

   logic        iopage_access;
   logic        ram_access;
   logic        ram_present;
   logic        ram_bus_error;
   logic        iopage_bus_error;
   logic        iopage_rd;
   logic        iopage_wr;
   logic [15:0] iopage_out;
   logic        grant_cpu;
   logic        grant_dma;
   logic        dma_req;
   logic [17:0] dma_addr;
   logic [15:0] dma_data_out;
   logic        dma_wr;

   // 17760000-17777777, bits 21:13 all ones
   assign iopage_access = (bus_addr[21:13] == pdp_bus_pkg::IOPAGE_BASE[21:13]);
   assign ram_access    = ~iopage_access;
   assign ram_present   = (bus_addr < 22'(RAM_BYTES));

   // the cpu access only completes on a cycle it owns the bus
   assign iopage_rd = grant_cpu & bus_rd & iopage_access;
   assign iopage_wr = grant_cpu & bus_wr & iopage_access;

   assign ram_bus_error = grant_cpu & ram_access & (bus_rd | bus_wr) & ~ram_present;
   assign bus_error     = iopage_bus_error | ram_bus_error;

   assign bus_data_out = iopage_access ? iopage_out : ram_data_in;

   // ram port belongs to whoever holds the grant
   assign ram_addr     = grant_cpu ? bus_addr : {4'b0000, dma_addr};
   assign ram_data_out = grant_cpu ? bus_data_in : dma_data_out;
   assign ram_rd       = grant_cpu & bus_rd & ram_access;
   assign ram_wr       = grant_cpu ? (bus_wr & ram_access & ram_present) : dma_wr;
   assign ram_byte_op  = grant_cpu & bus_byte_op;

   assign bus_ack = grant_cpu;

   bus_arbiter bus_arbiter_inst (
      .clk           (clk),
      .reset         (reset),
      .dma_req       (dma_req),
      .bus_arbitrate (bus_arbitrate),
      .grant_cpu     (grant_cpu),
      .grant_dma     (grant_dma)
   );

   iopage #(
      .TICK_CYCLES (TICK_CYCLES)
   ) iopage_inst (
      .clk            (clk),
      .reset          (reset),
      .address        (bus_addr),
      .data_in        (bus_data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (bus_byte_op),
      .switches       (switches),
      .ack_ipl        (interrupt_ack_ipl),
      .dma_ack        (grant_dma),
      .data_out       (iopage_out),
      .no_decode      (iopage_bus_error),
      .interrupt      (bus_int),
      .interrupt_ipl  (bus_int_ipl),
      .vector         (bus_int_vector),
      .display        (display),
      .dma_req        (dma_req),
      .dma_addr       (dma_addr),
      .dma_data_out   (dma_data_out),
      .dma_wr         (dma_wr)
   );

   // an errored access must leave memory untouched
   a_no_write_on_error: assert property (@(posedge clk) disable iff (reset)
      bus_error |-> !ram_wr);

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic clk,
   input  logic reset,
   input  logic dma_req,
   input  logic bus_arbitrate,
   output logic grant_cpu,
   output logic grant_dma
);

   pdp_bus_pkg::grant_state_t state;
   pdp_bus_pkg::grant_state_t state_next;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= pdp_bus_pkg::GRANT_CPU;
      else
         state <= state_next;
   end

   // leave the cpu only when it allows it, then at most four dma cycles
   always_comb
   begin
      state_next = pdp_bus_pkg::GRANT_CPU;
      case (state)
         pdp_bus_pkg::GRANT_CPU:
            if (dma_req && bus_arbitrate)
               state_next = pdp_bus_pkg::DMA1;
         pdp_bus_pkg::DMA1:
            if (dma_req)
               state_next = pdp_bus_pkg::DMA2;
         pdp_bus_pkg::DMA2:
            if (dma_req)
               state_next = pdp_bus_pkg::DMA3;
         pdp_bus_pkg::DMA3:
            if (dma_req)
               state_next = pdp_bus_pkg::DMA4;
         default:
            state_next = pdp_bus_pkg::GRANT_CPU;
      endcase
   end

   assign grant_cpu = (state == pdp_bus_pkg::GRANT_CPU);
   assign grant_dma = (state != pdp_bus_pkg::GRANT_CPU);

   // the cpu always gets the bus back after a burst of four
   a_burst_limit: assert property (@(posedge clk) disable iff (reset)
      grant_dma [*4] |=> grant_cpu);

endmodule

// File: fill_dma.sv
`timescale 1ns/1ps

module fill_dma (
   input  logic        clk,
   input  logic        reset,
   input  logic [1:0]  reg_sel,
   input  logic        reg_wr,
   input  logic        byte_op,
   input  logic [15:0] data_in,
   input  logic        dma_ack,
   input  logic        int_ack,
   output logic [15:0] reg_data,
   output logic        dma_req,
   output logic [17:0] dma_addr,
   output logic [15:0] dma_data_out,
   output logic        dma_wr,
   output logic        int_req
);

   pdp_bus_pkg::dma_state_t state;

   logic        ie;
   logic        done;
   logic [1:0]  xba;
   logic [15:0] wc;
   logic [15:0] ba;
   logic [15:0] fill;
   logic [15:0] csr;
   logic [15:0] wr_word;
   logic        last;

   // a byte write only reaches the low half
   assign wr_word = byte_op ? {8'h00, data_in[7:0]} : data_in;
   assign last    = (wc == 16'd1);

   assign dma_addr     = {xba, ba};
   assign dma_data_out = fill;
   assign dma_wr       = (state == pdp_bus_pkg::DMA_RUN) & dma_ack;
   // drop the request as the final word goes out so no grant is wasted
   assign dma_req      = (state == pdp_bus_pkg::DMA_RUN) & ~(dma_ack & last);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= pdp_bus_pkg::DMA_IDLE;
         ie      <= 1'b0;
         done    <= 1'b0;
         xba     <= 2'b00;
         wc      <= 16'h0000;
         ba      <= 16'h0000;
         fill    <= 16'h0000;
         int_req <= 1'b0;
      end
      else if (dma_wr)
      begin
         {xba, ba} <= {xba, ba} + 18'd2;
         wc        <= wc - 16'd1;
         if (last)
         begin
            state <= pdp_bus_pkg::DMA_IDLE;
            done  <= 1'b1;
            if (ie)
               int_req <= 1'b1;
         end
      end
      else
      begin
         if (int_ack)
            int_req <= 1'b0;
         if (reg_wr)
         begin
            case (reg_sel)
               2'd0:
               begin
                  ie  <= wr_word[pdp_bus_pkg::CSR_IE];
                  xba <= wr_word[5:4];
                  if (wr_word[pdp_bus_pkg::CSR_GO] && state == pdp_bus_pkg::DMA_IDLE)
                  begin
                     int_req <= 1'b0;
                     // an empty block finishes at once
                     if (wc == 16'd0)
                        done <= 1'b1;
                     else
                     begin
                        done  <= 1'b0;
                        state <= pdp_bus_pkg::DMA_RUN;
                     end
                  end
               end
               2'd1: wc <= byte_op ? {wc[15:8], wr_word[7:0]} : wr_word;
               2'd2: ba <= byte_op ? {ba[15:8], wr_word[7:0]} : wr_word;
               default: fill <= byte_op ? {fill[15:8], wr_word[7:0]} : wr_word;
            endcase
         end
      end
   end

   always_comb
   begin
      csr = 16'h0000;
      csr[pdp_bus_pkg::CSR_GO]   = (state == pdp_bus_pkg::DMA_RUN);
      csr[5:4]                   = xba;
      csr[pdp_bus_pkg::CSR_IE]   = ie;
      csr[pdp_bus_pkg::CSR_DONE] = done;
   end

   always_comb
   begin
      case (reg_sel)
         2'd0:    reg_data = csr;
         2'd1:    reg_data = wc;
         2'd2:    reg_data = ba;
         default: reg_data = fill;
      endcase
   end

   // every granted cycle carries a word, the grant ends with the last one
   a_grant_used: assert property (@(posedge clk) disable iff (reset)
      dma_ack |-> dma_wr);

endmodule

// File: iopage.sv
`timescale 1ns/1ps

module iopage #(
   parameter int TICK_CYCLES = 64
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] address,
   input  logic [15:0] data_in,
   input  logic        iopage_rd,
   input  logic        iopage_wr,
   input  logic        iopage_byte_op,
   input  logic [15:0] switches,
   input  logic [7:0]  ack_ipl,
   input  logic        dma_ack,
   output logic [15:0] data_out,
   output logic        no_decode,
   output logic        interrupt,
   output logic [7:0]  interrupt_ipl,
   output logic [7:0]  vector,
   output logic [15:0] display,
   output logic        dma_req,
   output logic [17:0] dma_addr,
   output logic [15:0] dma_data_out,
   output logic        dma_wr
);

   logic        sel_swr;
   logic        sel_lks;
   logic        sel_dma;
   logic        low_wr;
   logic [15:0] lks_status;
   logic [15:0] dma_reg_data;
   logic        lks_int_req;
   logic        dma_int_req;
   logic        lks_int_ack;
   logic        dma_int_ack;

   // word decode, bit 0 only picks the byte lane
   assign sel_swr = (address[21:1] == pdp_bus_pkg::SWR_ADDR[21:1]);
   assign sel_lks = (address[21:1] == pdp_bus_pkg::LKS_ADDR[21:1]);
   assign sel_dma = (address[21:1] == pdp_bus_pkg::DMA_CSR_ADDR[21:1])
                  | (address[21:1] == pdp_bus_pkg::DMA_WC_ADDR[21:1])
                  | (address[21:1] == pdp_bus_pkg::DMA_BA_ADDR[21:1])
                  | (address[21:1] == pdp_bus_pkg::DMA_DATA_ADDR[21:1]);

   // device registers take only low byte writes, a high byte write is dropped
   assign low_wr = iopage_wr & ~(iopage_byte_op & address[0]);

   assign no_decode = (iopage_rd | iopage_wr) & ~(sel_swr | sel_lks | sel_dma);

   always_ff @(posedge clk)
   begin
      if (reset)
         display <= 16'h0000;
      else if (iopage_wr && sel_swr)
      begin
         if (!iopage_byte_op)
            display <= data_in;
         else if (address[0])
            display[15:8] <= data_in[7:0];
         else
            display[7:0] <= data_in[7:0];
      end
   end

   always_comb
   begin
      data_out = 16'h0000;
      if (sel_swr)
         data_out = switches;
      else if (sel_lks)
         data_out = lks_status;
      else if (sel_dma)
         data_out = dma_reg_data;
   end

   // clock outranks the dma
   assign interrupt     = lks_int_req | dma_int_req;
   assign interrupt_ipl = lks_int_req ? pdp_bus_pkg::LKS_IPL :
                          dma_int_req ? pdp_bus_pkg::DMA_IPL : 8'h00;
   assign vector        = lks_int_req ? pdp_bus_pkg::LKS_VECTOR :
                          dma_int_req ? pdp_bus_pkg::DMA_VECTOR : 8'h00;

   assign lks_int_ack = |(ack_ipl & pdp_bus_pkg::LKS_IPL);
   assign dma_int_ack = |(ack_ipl & pdp_bus_pkg::DMA_IPL);

   line_clock #(
      .TICK_CYCLES (TICK_CYCLES)
   ) line_clock_inst (
      .clk     (clk),
      .reset   (reset),
      .sel_wr  (low_wr & sel_lks),
      .data_in (data_in),
      .int_ack (lks_int_ack),
      .status  (lks_status),
      .int_req (lks_int_req)
   );

   fill_dma fill_dma_inst (
      .clk          (clk),
      .reset        (reset),
      .reg_sel      (address[2:1]),
      .reg_wr       (low_wr & sel_dma),
      .byte_op      (iopage_byte_op),
      .data_in      (data_in),
      .dma_ack      (dma_ack),
      .int_ack      (dma_int_ack),
      .reg_data     (dma_reg_data),
      .dma_req      (dma_req),
      .dma_addr     (dma_addr),
      .dma_data_out (dma_data_out),
      .dma_wr       (dma_wr),
      .int_req      (dma_int_req)
   );

endmodule

// File: line_clock.sv
`timescale 1ns/1ps

module line_clock #(
   parameter int TICK_CYCLES = 64
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        sel_wr,
   input  logic [15:0] data_in,
   input  logic        int_ack,
   output logic [15:0] status,
   output logic        int_req
);

   localparam int CW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

   logic [CW-1:0] count;
   logic          tick;
   logic          flag;
   logic          ie;

   assign tick = (count == CW'(TICK_CYCLES - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count   <= '0;
         flag    <= 1'b0;
         ie      <= 1'b0;
         int_req <= 1'b0;
      end
      else
      begin
         count <= tick ? '0 : count + 1'b1;
         if (sel_wr)
            ie <= data_in[pdp_bus_pkg::CSR_IE];
         // a new tick wins over a clearing write
         if (tick)
            flag <= 1'b1;
         else if (sel_wr)
            flag <= 1'b0;
         if (tick && !flag && ie)
            int_req <= 1'b1;
         else if (int_ack || (sel_wr && !data_in[pdp_bus_pkg::CSR_IE]))
            int_req <= 1'b0;
      end
   end

   // flag reads back in the done position
   always_comb
   begin
      status = 16'h0000;
      status[pdp_bus_pkg::CSR_DONE] = flag;
      status[pdp_bus_pkg::CSR_IE]   = ie;
   end

endmodule

// File: pdp_bus_pkg.sv
package pdp_bus_pkg;

   // the i/o page is the top 8k bytes of the 22-bit physical space
   localparam logic [21:0] IOPAGE_BASE = 22'o17760000;

   // console switch register on read, display register on write
   localparam logic [21:0] SWR_ADDR = 22'o17777570;

   // line time clock status
   localparam logic [21:0] LKS_ADDR = 22'o17777546;

   // block fill dma controller
   localparam logic [21:0] DMA_CSR_ADDR  = 22'o17777440;
   localparam logic [21:0] DMA_WC_ADDR   = 22'o17777442;
   localparam logic [21:0] DMA_BA_ADDR   = 22'o17777444;
   localparam logic [21:0] DMA_DATA_ADDR = 22'o17777446;

   // csr bit positions, common to all devices
   localparam int CSR_GO   = 0;
   localparam int CSR_IE   = 6;
   localparam int CSR_DONE = 7;

   // interrupt vectors
   localparam logic [7:0] LKS_VECTOR = 8'o100;
   localparam logic [7:0] DMA_VECTOR = 8'o220;

   // one-hot interrupt levels
   localparam logic [7:0] LKS_IPL = 8'b0100_0000;
   localparam logic [7:0] DMA_IPL = 8'b0010_0000;

   typedef enum logic [2:0] {
      GRANT_CPU,
      DMA1,
      DMA2,
      DMA3,
      DMA4
   } grant_state_t;

   typedef enum logic {
      DMA_IDLE,
      DMA_RUN
   } dma_state_t;

endpackage

// File: pdp_sub_top.sv
`timescale 1ns/1ps

module pdp_sub_top #(
   parameter int RAM_BYTES   = 16384,
   parameter int TICK_CYCLES = 64
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] bus_addr,
   input  logic [15:0] bus_data_in,
   input  logic        bus_rd,
   input  logic        bus_wr,
   input  logic        bus_byte_op,
   input  logic        bus_arbitrate,
   input  logic [15:0] switches,
   input  logic [7:0]  interrupt_ack_ipl,
   output logic [15:0] bus_data_out,
   output logic        bus_ack,
   output logic        bus_error,
   output logic        bus_int,
   output logic [7:0]  bus_int_ipl,
   output logic [7:0]  bus_int_vector,
   output logic [15:0] display
);

   logic [21:0] ram_addr;
   logic [15:0] ram_wdata;
   logic [15:0] ram_rdata;
   logic        ram_rd;
   logic        ram_wr;
   logic        ram_byte_op;

   bus #(
      .RAM_BYTES   (RAM_BYTES),
      .TICK_CYCLES (TICK_CYCLES)
   ) bus_inst (
      .clk               (clk),
      .reset             (reset),
      .bus_addr          (bus_addr),
      .bus_data_in       (bus_data_in),
      .bus_rd            (bus_rd),
      .bus_wr            (bus_wr),
      .bus_byte_op       (bus_byte_op),
      .bus_arbitrate     (bus_arbitrate),
      .switches          (switches),
      .interrupt_ack_ipl (interrupt_ack_ipl),
      .bus_data_out      (bus_data_out),
      .bus_ack           (bus_ack),
      .bus_error         (bus_error),
      .bus_int           (bus_int),
      .bus_int_ipl       (bus_int_ipl),
      .bus_int_vector    (bus_int_vector),
      .display           (display),
      .ram_addr          (ram_addr),
      .ram_data_out      (ram_wdata),
      .ram_rd            (ram_rd),
      .ram_wr            (ram_wr),
      .ram_byte_op       (ram_byte_op),
      .ram_data_in       (ram_rdata)
   );

   word_ram #(
      .RAM_BYTES (RAM_BYTES)
   ) word_ram_inst (
      .clk      (clk),
      .addr     (ram_addr),
      .data_in  (ram_wdata),
      .rd       (ram_rd),
      .wr       (ram_wr),
      .byte_op  (ram_byte_op),
      .data_out (ram_rdata)
   );

endmodule

// File: tb_pdp_sub_tasks.svh
`ifndef TB_PDP_SUB_TASKS_SVH
`define TB_PDP_SUB_TASKS_SVH

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [15:0] rand_word();
   logic [15:0] w;
   int i;
   w = 16'h0000;
   for (i = 0; i < 16; i++)
   begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[14:0], lfsr_state[0]};
   end
   return w;
endfunction

task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_vector(input string what, input logic [7:0] got, input logic [7:0] exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("Mismatch at %0t ns: %s is %o, expected %o", $time, what, got, exp);
   end
endtask

// holds the request until bus_ack is seen, sampled at the falling edge
task automatic cpu_access(input logic [21:0] addr, input logic [15:0] wdata, input logic is_wr,
                          input logic is_byte, output logic [15:0] rdata, output logic err);
   int waited;
   waited = 0;
   rdata = 16'h0000;
   err = 1'b0;
   bus_addr = addr;
   bus_data_in = wdata;
   bus_rd = ~is_wr;
   bus_wr = is_wr;
   bus_byte_op = is_byte;
   @(negedge clk);
   while (!bus_ack && waited < ACK_TIMEOUT)
   begin
      waited++;
      @(negedge clk);
   end
   if (!bus_ack)
   begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: bus_ack never came for the access at %o", addr);
   end
   else
   begin
      rdata = bus_data_out;
      err = bus_error;
   end
   @(posedge clk);
   #DRIVE_DELAY;
   bus_rd = 1'b0;
   bus_wr = 1'b0;
   bus_byte_op = 1'b0;
endtask

task automatic cpu_write(input logic [21:0] addr, input logic [15:0] data, input logic is_byte,
                         output logic err);
   logic [15:0] unused_data;
   cpu_access(addr, data, 1'b1, is_byte, unused_data, err);
endtask

task automatic cpu_read(input logic [21:0] addr, output logic [15:0] data, output logic err);
   cpu_access(addr, 16'h0000, 1'b0, 1'b0, data, err);
endtask

task automatic poll_dma_done(output logic done);
   logic [15:0] csr;
   logic err;
   int polls;
   done = 1'b0;
   polls = 0;
   while (!done && !timed_out && polls < DMA_POLL_LIMIT)
   begin
      cpu_read(pdp_bus_pkg::DMA_CSR_ADDR, csr, err);
      done = csr[pdp_bus_pkg::CSR_DONE];
      polls++;
   end
   if (!done)
      $display("Timeout: DMA done bit still clear after %0d polls", polls);
endtask

task automatic wait_for_ipl(input logic [7:0] ipl, input int max_cycles, output logic seen);
   int waited;
   waited = 0;
   @(negedge clk);
   while (!(bus_int && bus_int_ipl == ipl) && waited < max_cycles)
   begin
      waited++;
      @(negedge clk);
   end
   seen = bus_int && (bus_int_ipl == ipl);
   if (!seen)
      $display("Timeout: no interrupt at level %b within %0d cycles", ipl, max_cycles);
   @(posedge clk);
   #DRIVE_DELAY;
endtask

task automatic pulse_int_ack(input logic [7:0] ipl);
   interrupt_ack_ipl = ipl;
   @(posedge clk);
   #DRIVE_DELAY;
   interrupt_ack_ipl = 8'h00;
endtask

`endif

// File: tb_pdp_sub.sv
`timescale 1ns/1ps

module tb_pdp_sub;

   localparam int RAM_BYTES      = 16384;
   localparam int TICK_CYCLES    = 64;
   localparam int AW             = $clog2(RAM_BYTES / 2);
   localparam int HALF_PERIOD    = 50;
   localparam int DRIVE_DELAY    = 5;
   localparam int ACK_TIMEOUT    = 20;
   localparam int DMA_POLL_LIMIT = 100;
   localparam logic [21:0] DMA_BASE = 22'o2000;
   localparam logic [21:0] INT_BASE = 22'o3000;
   localparam logic [15:0] GO_WORD  = 16'(1 << pdp_bus_pkg::CSR_GO);
   localparam logic [15:0] IE_WORD  = 16'(1 << pdp_bus_pkg::CSR_IE);

   logic        clk;
   logic        reset;
   logic [21:0] bus_addr;
   logic [15:0] bus_data_in;
   logic        bus_rd;
   logic        bus_wr;
   logic        bus_byte_op;
   logic        bus_arbitrate;
   logic [15:0] switches;
   logic [7:0]  interrupt_ack_ipl;
   logic [15:0] bus_data_out;
   logic        bus_ack;
   logic        bus_error;
   logic        bus_int;
   logic [7:0]  bus_int_ipl;
   logic [7:0]  bus_int_vector;
   logic [15:0] display;

   logic [31:0] lfsr_state;
   logic [15:0] ref_mem [RAM_BYTES / 2];
   logic        timed_out;
   int          errors;
   int          checks;
   int          tests_run;
   int          low_run;
   int          max_low_run;

   pdp_sub_top #(
      .RAM_BYTES   (RAM_BYTES),
      .TICK_CYCLES (TICK_CYCLES)
   ) pdp_sub_top_inst (
      .clk               (clk),
      .reset             (reset),
      .bus_addr          (bus_addr),
      .bus_data_in       (bus_data_in),
      .bus_rd            (bus_rd),
      .bus_wr            (bus_wr),
      .bus_byte_op       (bus_byte_op),
      .bus_arbitrate     (bus_arbitrate),
      .switches          (switches),
      .interrupt_ack_ipl (interrupt_ack_ipl),
      .bus_data_out      (bus_data_out),
      .bus_ack           (bus_ack),
      .bus_error         (bus_error),
      .bus_int           (bus_int),
      .bus_int_ipl       (bus_int_ipl),
      .bus_int_vector    (bus_int_vector),
      .display           (display)
   );

   always #HALF_PERIOD clk = ~clk;

   // longest run of cycles the cpu was kept off the bus
   always @(negedge clk)
   begin
      if (reset || bus_ack)
         low_run = 0;
      else
         low_run = low_run + 1;
      if (low_run > max_low_run)
         max_low_run = low_run;
   end

`include "tb_pdp_sub_tasks.svh"

   task automatic report_test(input string name, input int start_errors);
      tests_run++;
      $display("test %s finished with %0d errors", name, errors - start_errors);
   endtask

   task automatic test_ram_access();
      int start;
      int i;
      logic [21:0] a;
      logic [15:0] d;
      logic [15:0] got;
      logic err;
      start = errors;
      for (i = 0; i < 8; i++)
      begin
         a = 22'(64 + i * 36);
         d = rand_word();
         ref_mem[a[AW:1]] = d;
         cpu_write(a, d, 1'b0, err);
         check_flag("ram write error", err, 1'b0);
      end
      // byte data travels in the low half for either lane
      a = 22'(64 + 36 + 1);
      d = rand_word();
      ref_mem[a[AW:1]][15:8] = d[7:0];
      cpu_write(a, d, 1'b1, err);
      a = 22'(64 + 72);
      d = rand_word();
      ref_mem[a[AW:1]][7:0] = d[7:0];
      cpu_write(a, d, 1'b1, err);
      for (i = 0; i < 8; i++)
      begin
         a = 22'(64 + i * 36);
         cpu_read(a, got, err);
         check_word("ram read data", got, ref_mem[a[AW:1]]);
         check_flag("ram read error", err, 1'b0);
      end
      report_test("ram access", start);
   endtask

   task automatic test_bus_errors();
      int start;
      logic [15:0] d;
      logic [15:0] got;
      logic err;
      start = errors;
      d = rand_word();
      ref_mem[0] = d;
      cpu_write(22'd0, d, 1'b0, err);
      // the missing memory aliases onto word 0 in the array
      cpu_write(22'(RAM_BYTES), ~d, 1'b0, err);
      check_flag("error on write past memory", err, 1'b1);
      cpu_read(22'(RAM_BYTES), got, err);
      check_flag("error on read past memory", err, 1'b1);
      cpu_read(22'o17777000, got, err);
      check_flag("error on undecoded read", err, 1'b1);
      cpu_write(22'o17777000, d, 1'b0, err);
      check_flag("error on undecoded write", err, 1'b1);
      cpu_read(22'd0, got, err);
      check_word("word 0 after failed write", got, ref_mem[0]);
      check_flag("word 0 read error", err, 1'b0);
      report_test("bus errors", start);
   endtask

   task automatic test_console();
      int start;
      logic [15:0] d;
      logic [15:0] got;
      logic err;
      start = errors;
      switches = rand_word();
      cpu_read(pdp_bus_pkg::SWR_ADDR, got, err);
      check_word("switch register", got, switches);
      check_flag("switch read error", err, 1'b0);
      d = rand_word();
      cpu_write(pdp_bus_pkg::SWR_ADDR, d, 1'b0, err);
      check_flag("display write error", err, 1'b0);
      check_word("display", display, d);
      report_test("console", start);
   endtask

   task automatic test_fill_dma();
      int start;
      int i;
      logic [21:0] a;
      logic [15:0] fill;
      logic [15:0] got;
      logic err;
      logic done;
      start = errors;
      // block of ten plus one guard word on each side
      for (i = 0; i < 12; i++)
      begin
         a = DMA_BASE - 22'd2 + 22'(2 * i);
         ref_mem[a[AW:1]] = rand_word();
         cpu_write(a, ref_mem[a[AW:1]], 1'b0, err);
      end
      fill = rand_word();
      cpu_write(pdp_bus_pkg::DMA_DATA_ADDR, fill, 1'b0, err);
      cpu_write(pdp_bus_pkg::DMA_BA_ADDR, DMA_BASE[15:0], 1'b0, err);
      cpu_write(pdp_bus_pkg::DMA_WC_ADDR, 16'd10, 1'b0, err);
      bus_arbitrate = 1'b1;
      cpu_write(pdp_bus_pkg::DMA_CSR_ADDR, GO_WORD, 1'b0, err);
      poll_dma_done(done);
      check_flag("dma done", done, 1'b1);
      if (max_low_run > 4)
      begin
         errors++;
         $display("CPU was kept off the bus for %0d cycles in a row", max_low_run);
      end
      for (i = 1; i <= 10; i++)
      begin
         a = DMA_BASE - 22'd2 + 22'(2 * i);
         ref_mem[a[AW:1]] = fill;
      end
      for (i = 0; i < 12; i++)
      begin
         a = DMA_BASE - 22'd2 + 22'(2 * i);
         cpu_read(a, got, err);
         check_word("dma block word", got, ref_mem[a[AW:1]]);
      end
      report_test("fill dma", start);
   endtask

   task automatic test_interrupts();
      int start;
      logic err;
      logic done;
      logic seen;
      start = errors;
      bus_arbitrate = 1'b1;
      cpu_write(pdp_bus_pkg::DMA_DATA_ADDR, rand_word(), 1'b0, err);
      cpu_write(pdp_bus_pkg::DMA_BA_ADDR, INT_BASE[15:0], 1'b0, err);
      cpu_write(pdp_bus_pkg::DMA_WC_ADDR, 16'd2, 1'b0, err);
      cpu_write(pdp_bus_pkg::DMA_CSR_ADDR, GO_WORD | IE_WORD, 1'b0, err);
      poll_dma_done(done);
      check_flag("dma done", done, 1'b1);
      // a write landing on the tick keeps the flag, the second one clears it
      cpu_write(pdp_bus_pkg::LKS_ADDR, IE_WORD, 1'b0, err);
      cpu_write(pdp_bus_pkg::LKS_ADDR, IE_WORD, 1'b0, err);
      wait_for_ipl(pdp_bus_pkg::LKS_IPL, 3 * TICK_CYCLES, seen);
      check_flag("line clock interrupt seen", seen, 1'b1);
      check_flag("bus_int with both pending", bus_int, 1'b1);
      check_vector("level with both pending", bus_int_ipl, pdp_bus_pkg::LKS_IPL);
      check_vector("vector with both pending", bus_int_vector, pdp_bus_pkg::LKS_VECTOR);
      pulse_int_ack(pdp_bus_pkg::LKS_IPL);
      check_flag("bus_int after clock ack", bus_int, 1'b1);
      check_vector("level after clock ack", bus_int_ipl, pdp_bus_pkg::DMA_IPL);
      check_vector("vector after clock ack", bus_int_vector, pdp_bus_pkg::DMA_VECTOR);
      pulse_int_ack(pdp_bus_pkg::DMA_IPL);
      check_flag("bus_int after dma ack", bus_int, 1'b0);
      report_test("interrupts", start);
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      bus_addr = 22'd0;
      bus_data_in = 16'h0000;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      bus_byte_op = 1'b0;
      bus_arbitrate = 1'b0;
      switches = 16'h0000;
      interrupt_ack_ipl = 8'h00;
      lfsr_state = 32'h612f_f535;
      timed_out = 1'b0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      low_run = 0;
      max_low_run = 0;
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      @(posedge clk);
      #DRIVE_DELAY;
      test_ram_access();
      if (!timed_out)
         test_bus_errors();
      if (!timed_out)
         test_console();
      if (!timed_out)
         test_fill_dma();
      if (!timed_out)
         test_interrupts();
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0 && !timed_out)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram #(
   parameter int RAM_BYTES = 16384
) (
   input  logic        clk,
   input  logic [21:0] addr,
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   input  logic        byte_op,
   output logic [15:0] data_out
);

   localparam int WORDS = RAM_BYTES / 2;
   localparam int AW    = $clog2(WORDS);

   logic [15:0]   mem [WORDS];
   logic [AW-1:0] word_addr;

   // addresses past the array wrap, the bus flags them as errors
   assign word_addr = addr[AW:1];

   assign data_out = rd ? mem[word_addr] : 16'h0000;

   // byte data always arrives in the low half and lands in the lane of addr[0]
   always_ff @(posedge clk)
   begin
      if (wr)
      begin
         if (!byte_op)
            mem[word_addr] <= data_in;
         else if (addr[0])
            mem[word_addr][15:8] <= data_in[7:0];
         else
            mem[word_addr][7:0] <= data_in[7:0];
      end
   end

endmodule
